/* vlsu_cfg_pkg.sv */
// Bus and lane-buffer geometry of the sequential load path
// Load request command type

`default_nettype none

package vlsu_cfg_pkg;

  // =========================================================================
  // Bus geometry
  // =========================================================================

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned BusBytes       = 4;
  localparam int unsigned BusNibbles     = 2 * BusBytes;
  localparam int unsigned ByteIdxWidth   = $clog2(BusBytes);
  localparam int unsigned BusNibIdxWidth = $clog2(BusNibbles);
  localparam int unsigned WordIdxWidth   = AddrWidth - ByteIdxWidth;

  // Nibble addresses span the full byte address space
  localparam int unsigned NibAddrWidth   = WordIdxWidth + BusNibIdxWidth;

  // =========================================================================
  // Lane buffer geometry
  // =========================================================================

  localparam int unsigned NrLanes        = 3;
  localparam int unsigned LaneNibbles    = 4;
  // 12 nibbles per entry, so entries and bus words do not line up
  localparam int unsigned EntryNibbles   = NrLanes * LaneNibbles;
  localparam int unsigned EntryIdxWidth  = $clog2(EntryNibbles);

  // Request length in nibbles, 1 to 255
  localparam int unsigned LenWidth       = 8;

  typedef struct packed {
    logic [NibAddrWidth-1:0] addr;
    logic [LenWidth-1:0]     len;
  } load_req_t;

endpackage

`default_nettype wire

/* vlsu_bus_pkg.sv */
// AXI4-Lite read channel payloads
// Transaction record and lane-buffer entry types

`default_nettype none

package vlsu_bus_pkg;

  localparam int unsigned DataWidth = 8 * vlsu_cfg_pkg::BusBytes;

  // Unprivileged, secure, data access
  localparam logic [2:0] ArProtData = 3'b000;

  // =========================================================================
  // AXI4-Lite read channels
  // =========================================================================

  typedef struct packed {
    logic [vlsu_cfg_pkg::AddrWidth-1:0] addr;
    logic [2:0]                         prot;
  } axi_ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
  } axi_r_t;

  // =========================================================================
  // Internal records
  // =========================================================================

  // One issued read, valid nibbles are head up to tail-1
  typedef struct packed {
    logic [vlsu_cfg_pkg::BusNibIdxWidth-1:0] head;
    logic [vlsu_cfg_pkg::BusNibIdxWidth:0]   tail;
    logic                                    final_beat;
  } txn_rec_t;

  // Packed lane-buffer entry toward the shuffle stage
  typedef struct packed {
    logic [vlsu_cfg_pkg::EntryNibbles-1:0][3:0] nib;
    logic [vlsu_cfg_pkg::EntryNibbles-1:0]      en;
    logic                                       last;
  } seq_entry_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
// Valid/ready FIFO with a payload type parameter
// Circular storage, pointers carry a wrap flag

`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic push_valid_i,
  output logic push_ready_o,
  input  T     push_data_i,

  output logic pop_valid_o,
  input  logic pop_ready_i,
  output T     pop_data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrWidth-1:0] LastIdx = PtrWidth'(Depth - 1);

  T mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic                wr_flag_q, rd_flag_q;
  logic                full, empty;
  logic                push, pop;

  // Same index, the wrap flags tell full from empty
  assign empty = (wr_ptr_q == rd_ptr_q) && (wr_flag_q == rd_flag_q);
  assign full  = (wr_ptr_q == rd_ptr_q) && (wr_flag_q != rd_flag_q);

  assign push_ready_o = ~full;
  assign pop_valid_o  = ~empty;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & ~full;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      wr_flag_q <= 1'b0;
      rd_ptr_q  <= '0;
      rd_flag_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q  <= (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
        wr_flag_q <= wr_flag_q ^ (wr_ptr_q == LastIdx);
      end
      if (pop) begin
        rd_ptr_q  <= (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
        rd_flag_q <= rd_flag_q ^ (rd_ptr_q == LastIdx);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

/* load_txn_gen.sv */
// Transaction generator of the sequential load path
// Splits a load request into single-word AXI4-Lite reads
// and one transaction record per read

`timescale 1ns/100ps
`default_nettype none

module load_txn_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Load request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  vlsu_cfg_pkg::load_req_t req_i,

  // AXI4-Lite read address
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output vlsu_bus_pkg::axi_ar_t   ar_o,

  // Transaction records toward the packer
  output logic                    rec_valid_o,
  input  logic                    rec_ready_i,
  output vlsu_bus_pkg::txn_rec_t  rec_o
);

  import vlsu_cfg_pkg::*;
  import vlsu_bus_pkg::*;

  localparam int unsigned CntWidth = BusNibIdxWidth + 1;

  typedef enum logic {
    GenIdle,
    GenIssue
  } gen_state_e;

  gen_state_e state_q, state_d;

  // Current word, head offset and nibbles still owed from this word on
  logic [WordIdxWidth-1:0]   word_q;
  logic [BusNibIdxWidth-1:0] head_q;
  logic [LenWidth-1:0]       rem_q;

  logic [CntWidth-1:0] avail;
  logic                is_final;
  logic                req_fire;
  logic                ar_fire;

  // =========================================================================
  // Per-word bounds
  // =========================================================================

  // Nibbles the current word can supply from its head upward
  assign avail    = CntWidth'(BusNibbles) - {1'b0, head_q};
  assign is_final = rem_q <= LenWidth'(avail);

  assign rec_o.head       = head_q;
  assign rec_o.tail       = is_final ? {1'b0, head_q} + rem_q[CntWidth-1:0]
                                     : CntWidth'(BusNibbles);
  assign rec_o.final_beat = is_final;

  assign ar_o.addr = {word_q, {ByteIdxWidth{1'b0}}};
  assign ar_o.prot = ArProtData;

  // =========================================================================
  // Handshakes
  // =========================================================================

  assign req_ready_o = (state_q == GenIdle);
  assign req_fire    = req_valid_i & req_ready_o;

  // AR and record advance together, so a read is only offered with queue space
  assign ar_valid_o  = (state_q == GenIssue) & rec_ready_i;
  assign rec_valid_o = (state_q == GenIssue) & ar_ready_i;
  assign ar_fire     = ar_valid_o & ar_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      GenIdle: begin
        if (req_fire) begin
          state_d = GenIssue;
        end
      end
      GenIssue: begin
        if (ar_fire && is_final) begin
          state_d = GenIdle;
        end
      end
      default: begin
        state_d = GenIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GenIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Only the first word of a request starts off the word boundary
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      word_q <= req_i.addr[NibAddrWidth-1:BusNibIdxWidth];
      head_q <= req_i.addr[BusNibIdxWidth-1:0];
      rem_q  <= req_i.len;
    end else if (ar_fire) begin
      word_q <= word_q + 1'b1;
      head_q <= '0;
      rem_q  <= rem_q - LenWidth'(avail);
    end
  end

endmodule

`default_nettype wire

/* seq_load_packer.sv */
// Sequential load packer
// Moves the requested nibbles of each R beat into lane-buffer entries,
// pushing an entry when it is full or the request ends

`timescale 1ns/100ps
`default_nettype none

module seq_load_packer (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // AXI4-Lite read data
  input  logic                     r_valid_i,
  output logic                     r_ready_o,
  input  vlsu_bus_pkg::axi_r_t     r_i,

  // Transaction records, one per beat and in AR order
  input  logic                     rec_valid_i,
  output logic                     rec_ready_o,
  input  vlsu_bus_pkg::txn_rec_t   rec_i,

  // Packed entries toward the entry buffer
  output logic                     entry_valid_o,
  input  logic                     entry_ready_i,
  output vlsu_bus_pkg::seq_entry_t entry_o
);

  import vlsu_cfg_pkg::*;
  import vlsu_bus_pkg::*;

  localparam int unsigned CntWidth  = BusNibIdxWidth + 1;
  localparam int unsigned FillWidth = EntryIdxWidth + 1;

  // Entry under construction
  seq_entry_t                entry_q, entry_d;
  logic [EntryIdxWidth-1:0]  fill_q;
  // Nibbles of the current beat already placed in an earlier entry
  logic [BusNibIdxWidth-1:0] taken_q;

  logic [CntWidth-1:0]  lo;
  logic [CntWidth-1:0]  bus_left;
  logic [FillWidth-1:0] space;
  logic [FillWidth-1:0] move;
  logic                 active;
  logic                 fits;
  logic                 push;

  // =========================================================================
  // Move amount
  // =========================================================================

  // Nothing is consumed while the entry buffer is full
  assign active = r_valid_i & rec_valid_i & entry_ready_i;

  assign lo       = {1'b0, rec_i.head} + {1'b0, taken_q};
  assign bus_left = rec_i.tail - lo;
  assign space    = FillWidth'(EntryNibbles) - {1'b0, fill_q};

  // Beat remainder fits, otherwise fill the entry and keep the beat
  assign fits = FillWidth'(bus_left) <= space;
  assign move = fits ? FillWidth'(bus_left) : space;

  // Entry full, or final beat of the request placed
  assign push = active & (~fits | (FillWidth'(bus_left) == space) | rec_i.final_beat);

  // =========================================================================
  // Handshakes
  // =========================================================================

  // Beat and record leave together once the beat is fully placed
  assign r_ready_o   = active & fits;
  assign rec_ready_o = active & fits;

  assign entry_valid_o = push;
  assign entry_o       = entry_d;

  // =========================================================================
  // Nibble placement
  // =========================================================================

  always_comb begin
    int src;
    entry_d      = entry_q;
    entry_d.last = rec_i.final_beat & fits;
    for (int i = 0; i < EntryNibbles; i++) begin
      // Entry slot i takes bus nibble src
      src = i - int'(fill_q) + int'(lo);
      if ((i >= int'(fill_q)) && (i < int'(fill_q) + int'(move))) begin
        entry_d.nib[i] = r_i.data[src*4 +: 4];
        entry_d.en[i]  = 1'b1;
      end
    end
  end

  // =========================================================================
  // State
  // =========================================================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
      fill_q  <= '0;
      taken_q <= '0;
    end else if (active) begin
      if (push) begin
        // Start a clean entry, unused nibbles read as zero
        entry_q <= '0;
        fill_q  <= '0;
      end else begin
        entry_q <= entry_d;
        fill_q  <= fill_q + EntryIdxWidth'(move);
      end
      if (fits) begin
        taken_q <= '0;
      end else begin
        taken_q <= taken_q + BusNibIdxWidth'(move);
      end
    end
  end

endmodule

`default_nettype wire

/* vlsu_seq_load_top.sv */
// Top level of the sequential load path
// Generator, record FIFO, packer and entry FIFO

`timescale 1ns/100ps
`default_nettype none

module vlsu_seq_load_top #(
  parameter int unsigned RecDepth   = 4,
  parameter int unsigned EntryDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Load request
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  vlsu_cfg_pkg::load_req_t  req_i,

  // AXI4-Lite read master, AR and R only
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  output vlsu_bus_pkg::axi_ar_t    ar_o,
  input  logic                     r_valid_i,
  output logic                     r_ready_o,
  input  vlsu_bus_pkg::axi_r_t     r_i,

  // Packed entries toward the shuffle stage
  output logic                     entry_valid_o,
  input  logic                     entry_ready_i,
  output vlsu_bus_pkg::seq_entry_t entry_o
);

  import vlsu_bus_pkg::*;

  // Generator to record queue
  logic       gen_rec_valid;
  logic       gen_rec_ready;
  txn_rec_t   gen_rec;

  // Record queue to packer
  logic       pk_rec_valid;
  logic       pk_rec_ready;
  txn_rec_t   pk_rec;

  // Packer to entry buffer
  logic       pk_entry_valid;
  logic       pk_entry_ready;
  seq_entry_t pk_entry;

  load_txn_gen i_txn_gen (
    .clk_i       (clk_i        ),
    .rst_ni      (rst_ni       ),
    .req_valid_i (req_valid_i  ),
    .req_ready_o (req_ready_o  ),
    .req_i       (req_i        ),
    .ar_valid_o  (ar_valid_o   ),
    .ar_ready_i  (ar_ready_i   ),
    .ar_o        (ar_o         ),
    .rec_valid_o (gen_rec_valid),
    .rec_ready_i (gen_rec_ready),
    .rec_o       (gen_rec      )
  );

  stream_fifo #(
    .T     (txn_rec_t),
    .Depth (RecDepth )
  ) i_rec_fifo (
    .clk_i        (clk_i        ),
    .rst_ni       (rst_ni       ),
    .push_valid_i (gen_rec_valid),
    .push_ready_o (gen_rec_ready),
    .push_data_i  (gen_rec      ),
    .pop_valid_o  (pk_rec_valid ),
    .pop_ready_i  (pk_rec_ready ),
    .pop_data_o   (pk_rec       )
  );

  seq_load_packer i_packer (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .r_valid_i     (r_valid_i     ),
    .r_ready_o     (r_ready_o     ),
    .r_i           (r_i           ),
    .rec_valid_i   (pk_rec_valid  ),
    .rec_ready_o   (pk_rec_ready  ),
    .rec_i         (pk_rec        ),
    .entry_valid_o (pk_entry_valid),
    .entry_ready_i (pk_entry_ready),
    .entry_o       (pk_entry      )
  );

  // Ping-pong style buffer in front of the shuffle stage
  stream_fifo #(
    .T     (seq_entry_t),
    .Depth (EntryDepth )
  ) i_entry_fifo (
    .clk_i        (clk_i         ),
    .rst_ni       (rst_ni        ),
    .push_valid_i (pk_entry_valid),
    .push_ready_o (pk_entry_ready),
    .push_data_i  (pk_entry      ),
    .pop_valid_o  (entry_valid_o ),
    .pop_ready_i  (entry_ready_i ),
    .pop_data_o   (entry_o       )
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and reset generator
// Free running clock, reset released between edges after a fixed count

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release clear of both edges so no flop sees it at a clock edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_vlsu_seq_load.sv */
// Testbench of the sequential load path
// AXI4-Lite memory model, reference model of the packed entries,
// directed and random load requests with checks

`timescale 1ns/100ps
`default_nettype none

module tb_vlsu_seq_load;

  import vlsu_cfg_pkg::*;
  import vlsu_bus_pkg::*;

  localparam int unsigned MemWords = 64;
  localparam int unsigned MemIdxW  = $clog2(MemWords);
  localparam int unsigned Limit    = 20000;
  localparam int unsigned NrRand   = 30;
  localparam int unsigned NrB2b    = 8;

  logic       clk;
  logic       rst_n;
  logic       req_valid = 1'b0;
  logic       req_ready;
  load_req_t  req = '0;
  logic       ar_valid;
  logic       ar_ready = 1'b0;
  axi_ar_t    ar;
  logic       r_valid = 1'b0;
  logic       r_ready;
  axi_r_t     r = '0;
  logic       entry_valid;
  logic       entry_ready = 1'b0;
  seq_entry_t entry;

  logic [31:0] mem [MemWords];
  integer      seed = 32'h769b_25dd;
  seq_entry_t  exp_q [$];
  // Word indices of accepted ARs in the order they are answered
  int unsigned rq [$];
  logic        mem_delay = 1'b0;
  logic        bp_en = 1'b0;
  logic        r_busy = 1'b0;
  logic        req_seen = 1'b0;
  logic        req_open = 1'b0;
  logic        aborted = 1'b0;
  int unsigned err_cnt = 0;
  int unsigned pass_cnt = 0;
  int unsigned fail_cnt = 0;
  int unsigned ar_cnt = 0;
  int unsigned exp_words = 0;
  int unsigned next_word = 0;
  int unsigned rnd_addr [NrRand + NrB2b];
  int unsigned rnd_len [NrRand + NrB2b];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk  ),
    .rst_no (rst_n)
  );

  vlsu_seq_load_top #(
    .RecDepth   (4),
    .EntryDepth (2)
  ) dut (
    .clk_i         (clk        ),
    .rst_ni        (rst_n      ),
    .req_valid_i   (req_valid  ),
    .req_ready_o   (req_ready  ),
    .req_i         (req        ),
    .ar_valid_o    (ar_valid   ),
    .ar_ready_i    (ar_ready   ),
    .ar_o          (ar         ),
    .r_valid_i     (r_valid    ),
    .r_ready_o     (r_ready    ),
    .r_i           (r          ),
    .entry_valid_o (entry_valid),
    .entry_ready_i (entry_ready),
    .entry_o       (entry      )
  );

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s: expected %0h, actual %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Nibble a of the memory with the low nibble of each word first
  function automatic logic [3:0] mem_nibble(input int unsigned a);
    logic [31:0] w;
    w = mem[MemIdxW'((a / BusNibbles) % MemWords)];
    return w[(a % BusNibbles) * 4 +: 4];
  endfunction

  // Reference model that cuts the nibble range into chunks of one entry
  task automatic expect_entries(input int unsigned addr, input int unsigned len);
    seq_entry_t  e;
    int unsigned slot;
    e = '0;
    for (int unsigned k = 0; k < len; k++) begin
      slot        = k % EntryNibbles;
      e.nib[slot] = mem_nibble(addr + k);
      e.en[slot]  = 1'b1;
      if ((slot == EntryNibbles - 1) || (k == len - 1)) begin
        e.last = (k == len - 1);
        exp_q.push_back(e);
        e = '0;
      end
    end
  endtask

  task automatic check_entry(input seq_entry_t exp, input seq_entry_t act);
    logic [EntryNibbles*4-1:0] mask;
    for (int i = 0; i < EntryNibbles; i++) begin
      mask[i*4 +: 4] = {4{exp.en[i]}};
    end
    check_value("entry_o.en", exp.en, act.en);
    check_value("entry_o.nib", exp.nib & mask, act.nib & mask);
    check_value("entry_o.last", exp.last, act.last);
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_req(input int unsigned addr, input int unsigned len);
    int unsigned n;
    if (aborted) return;
    expect_entries(addr, len);
    req.addr  = NibAddrWidth'(addr);
    req.len   = LenWidth'(len);
    req_valid = 1'b1;
    req_seen  = 1'b0;
    n = 0;
    while (!req_seen && n < Limit) begin
      @(negedge clk);
      n++;
    end
    req_valid = 1'b0;
    if (!req_seen) begin
      $display("Timeout: load request at nibble %0d was never accepted", addr);
      aborted = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic wait_drained();
    int unsigned n;
    n = 0;
    while (!aborted && n < Limit && (exp_q.size() != 0 || req_open)) begin
      @(negedge clk);
      n++;
    end
    if (!aborted && (exp_q.size() != 0 || req_open)) begin
      $display("Timeout: %0d entries still missing after %0d cycles", exp_q.size(), Limit);
      aborted = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("[ok]   %s", name);
    end else begin
      fail_cnt++;
      $display("[bad]  %s, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ==========================================================================
  // AXI4-Lite memory model and entry monitor
  // ==========================================================================

  // Drive on the falling edge and sample the handshakes that the next
  // rising edge completes
  always @(negedge clk) begin
    logic [31:0] rnd_ar;
    logic [31:0] rnd_r;
    logic [31:0] rnd_bp;
    int unsigned a;
    rnd_ar = $random(seed);
    rnd_r  = $random(seed);
    rnd_bp = $random(seed);
    ar_ready    = !mem_delay || (rnd_ar[1:0] != 2'b00);
    entry_ready = !bp_en || rnd_bp[0];
    // RVALID and data hold until the beat is taken
    if (!r_busy) begin
      r_valid = (rq.size() != 0) && (!mem_delay || (rnd_r[1:0] != 2'b00));
      if (r_valid) begin
        r.data = mem[MemIdxW'(rq[0] % MemWords)];
        r.resp = 2'b00;
      end
      r_busy = r_valid;
    end
    #1;
    if (rst_n) begin
      // Generator must be idle again the cycle after the final AR
      if (req_open && (req_ready || ar_cnt == exp_words)) begin
        check_value("AR count", exp_words, ar_cnt);
        check_value("req_ready_o", 1'b1, req_ready);
        req_open = 1'b0;
      end
      if (req_valid && req_ready) begin
        a         = 32'(req.addr);
        req_seen  = 1'b1;
        req_open  = 1'b1;
        ar_cnt    = 0;
        next_word = a / BusNibbles;
        exp_words = (a + int'(req.len) - 1) / BusNibbles - next_word + 1;
      end
      if (ar_valid && ar_ready) begin
        if (!req_open) begin
          $display("AR issued at %0t with no load request open", $time);
          err_cnt++;
        end
        check_value("ar_o.addr", next_word * BusBytes, ar.addr);
        // Plain data reads are unprivileged and secure
        check_value("ar_o.prot", 3'b000, ar.prot);
        rq.push_back(ar.addr / BusBytes);
        next_word++;
        ar_cnt++;
      end
      if (r_valid && r_ready) begin
        void'(rq.pop_front());
        r_busy = 1'b0;
      end
      if (entry_valid && entry_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected entry at %0t with no load outstanding", $time);
          err_cnt++;
        end else begin
          check_entry(exp_q.pop_front(), entry);
        end
      end
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    int unsigned errs;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = $random(seed);
    end
    // Random requests stay inside the modelled memory
    for (int i = 0; i < NrRand + NrB2b; i++) begin
      rnd_len[i]  = $unsigned($random(seed)) % 255 + 1;
      rnd_addr[i] = $unsigned($random(seed)) % (MemWords * BusNibbles + 1 - rnd_len[i]);
    end
    repeat (6) @(negedge clk);

    errs = err_cnt;
    send_req(2 * BusNibbles + 2, 5);
    wait_drained();
    finish_test("short request inside one word", errs);

    errs = err_cnt;
    send_req(37, 40);
    wait_drained();
    finish_test("unaligned request over several entries", errs);

    errs = err_cnt;
    send_req(3, 3 * EntryNibbles);
    wait_drained();
    finish_test("length multiple of the entry size", errs);

    errs = err_cnt;
    bp_en = 1'b1;
    for (int i = 0; i < NrRand; i++) begin
      send_req(rnd_addr[i], rnd_len[i]);
      wait_drained();
    end
    finish_test("random requests with back-pressure", errs);

    errs = err_cnt;
    mem_delay = 1'b1;
    for (int i = NrRand; i < NrRand + NrB2b; i++) begin
      send_req(rnd_addr[i], rnd_len[i]);
    end
    wait_drained();
    finish_test("back-to-back requests with memory delays", errs);

    // A few idle cycles catch stray entries
    repeat (20) @(negedge clk);
    $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !aborted) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
vlsu_cfg_pkg.sv
vlsu_bus_pkg.sv
stream_fifo.sv
load_txn_gen.sv
seq_load_packer.sv
vlsu_seq_load_top.sv
tb_clk_gen.sv
tb_vlsu_seq_load.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the sequential load testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f files.f \
  --top-module tb_vlsu_seq_load \
  -Mdir "$BUILD_DIR" \
  -o sim

"./$BUILD_DIR/sim" | tee "$LOG"

if grep -q "^Test passed$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see $LOG"
  exit 1
fi
